// File: mcpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_decode (
  input  logic [31:0]          inst,
  input  logic [31:0]          nextinst,
  input  logic                 prev_long_imm,
  input  logic [2:0]           preds,
  input  logic [31:0]          reg_scoreboard,
  input  logic [2:0]           pred_scoreboard,
  input  logic [31:0]          rs_data,
  input  logic [31:0]          rt_data,
  output logic [4:0]           rs_num,
  output logic [4:0]           rt_num,
  output mcpu_pipe_pkg::d2pc_t decoded,
  output logic                 dep_stall
);

  import mcpu_isa_pkg::*;

  logic [8:0]         opcode;
  logic [num_preds:0] pred_ext;      // Predicates plus the always-true entry
  logic [num_preds:0] pred_sb_ext;
  logic               pred_true;
  logic               is_cmp;
  logic               pred_dst_ok;
  logic               depend_rs;
  logic               depend_rt;

  assign opcode      = {inst[23:19], inst[13:10]};
  assign rs_num      = inst[4:0];
  assign rt_num      = inst[18:14];
  assign pred_ext    = {1'b1, preds};
  assign pred_sb_ext = {1'b0, pred_scoreboard};
  assign pred_true   = (pred_ext[inst[31:30]] ^ inst[29]) & ~prev_long_imm;
  assign is_cmp      = opcode[3:0] == cmp_opcode;
  assign pred_dst_ok = inst[6:5] != 2'd3;            // Writes to the true predicate are dropped

  always_comb begin
    decoded                = '0;
    decoded.execute_opcode = opcode;
    decoded.rd_num         = inst[9:5];
    decoded.oper_type      = oper_alu;
    decoded.lsu_offset     = opcode[2] ? {inst[24:19], inst[13], inst[9:5]} : inst[24:13];
    depend_rs              = 1'b0;
    depend_rt              = 1'b0;

    if (pred_true) begin
      if (!inst[28]) begin                           // ALU short immediate
        decoded.rd_we        = ~is_cmp;
        decoded.pred_we      = is_cmp & pred_dst_ok;
        decoded.shift_type   = 2'b11;                // Rotate of the 10-bit immediate
        decoded.shift_amount = {1'b0, inst[17:14], 1'b0};
        decoded.sop[9:0]     = inst[27:18];
        if (opcode[3]) begin
          decoded.sop[14:10] = inst[4:0];            // One-operand form widens the immediate
        end else begin
          depend_rs = 1'b1;
        end
      end else if (inst[27:26] == 2'b01) begin       // ALU register
        decoded.sop          = rt_data;
        decoded.rd_we        = ~is_cmp;
        decoded.pred_we      = is_cmp & pred_dst_ok;
        decoded.shift_amount = {1'b0, inst[25:21]};
        decoded.shift_type   = inst[20:19];
        depend_rt            = 1'b1;
        depend_rs            = ~opcode[3];
      end else if (inst[27:25] == 3'b001) begin      // Load or store
        decoded.oper_type = oper_lsu;
        decoded.sop       = rt_data;
        decoded.rd_we     = ~opcode[2];              // Stores write nothing
        depend_rs         = 1'b1;
        depend_rt         = opcode[2];
      end else if (inst[27]) begin                   // Branch
        decoded.oper_type = oper_branch;
        decoded.rd_num    = branch_link_reg;
        decoded.rd_we     = inst[25];                // Link
        decoded.branchreg = inst[26];
        if (inst[26]) begin
          depend_rs            = 1'b1;
          decoded.sop[27:0]    = {{8{inst[24]}}, inst[24:5]};
        end else begin
          decoded.sop[27:0]    = {{3{inst[24]}}, inst[24:0]};
        end
      end else if (inst[24]) begin                   // Other group
        decoded.oper_type = oper_other;
        decoded.sop       = rt_data;
        case (other_op_e'(opcode[8:5]))
          other_break, other_syscall, other_fence, other_eret: begin
          end
          other_flush, other_mtc, other_mthi: begin
            depend_rs = 1'b1;
          end
          other_mfc, other_mfhi: begin
            decoded.rd_we = 1'b1;
          end
          other_mult, other_div: begin
            depend_rs     = 1'b1;
            depend_rt     = 1'b1;
            decoded.rd_we = 1'b1;
          end
          default: begin
            decoded.invalid = 1'b1;
          end
        endcase
      end else if (|inst[23:22]) begin
        decoded.invalid = 1'b1;
      end else if (inst[21]) begin                   // Register shift
        depend_rs            = 1'b1;
        depend_rt            = 1'b1;
        decoded.rd_we        = 1'b1;
        decoded.shift_type   = inst[20:19];
        // Only whether the amount reaches 32 matters above bit 4
        decoded.shift_amount = {|rs_data[31:5], rs_data[4:0]};
        decoded.sop          = rt_data;
      end else if (|inst[20:14]) begin
        decoded.invalid = 1'b1;
      end else begin                                 // ALU long immediate
        decoded.sop      = nextinst;
        decoded.long_imm = 1'b1;
        depend_rs        = ~opcode[3];
        decoded.rd_we    = ~is_cmp;
        decoded.pred_we  = is_cmp & pred_dst_ok;
      end
    end

    assert (!(decoded.rd_we && decoded.pred_we))
      else $error("decode: register and predicate write enabled together");
  end

  // Guard predicate only matters when the word is an instruction
  assign dep_stall = (depend_rt & reg_scoreboard[rt_num]) |
                     (depend_rs & reg_scoreboard[rs_num]) |
                     (pred_sb_ext[inst[31:30]] & ~prev_long_imm) |
                     (decoded.rd_we & reg_scoreboard[decoded.rd_num]) |
                     (decoded.pred_we & pred_sb_ext[decoded.rd_num[1:0]]);

endmodule

`default_nettype wire

// File: mcpu_decode_reg.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_decode_reg (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fire,
  input  mcpu_pipe_pkg::d2pc_t decoded,
  output mcpu_pipe_pkg::d2pc_t issue,
  output logic                 prev_long_imm
);

  import mcpu_isa_pkg::*;
  import mcpu_pipe_pkg::*;

  d2pc_t payload_q;
  logic  valid_q;

  always_ff @(posedge clk) begin
    if (fire) begin
      payload_q <= decoded;
    end
  end

  // Valid lasts a single cycle per accepted word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q       <= 1'b0;
      prev_long_imm <= 1'b0;
    end else begin
      valid_q <= fire;
      if (fire) begin
        prev_long_imm <= decoded.long_imm;           // Next accepted word is the immediate
      end
    end
  end

  always_comb begin
    issue       = payload_q;
    issue.valid = valid_q;
  end

  // The immediate word itself goes down the pipe as a bubble
  a_imm_bubble: assert property (
    @(posedge clk) disable iff (!rst_n)
    fire && prev_long_imm |=> issue.valid && !issue.rd_we && !issue.pred_we && !issue.long_imm
  ) else $error("decode_reg: long immediate word issued with side effects");

  a_long_imm_alu: assert property (
    @(posedge clk) disable iff (!rst_n)
    issue.valid && issue.long_imm |-> issue.oper_type == oper_alu
  ) else $error("decode_reg: long immediate outside the ALU");

endmodule

`default_nettype wire

// File: mcpu_decode_stage.f
mcpu_isa_pkg.sv
mcpu_pipe_pkg.sv
mcpu_decode.sv
mcpu_regfile.sv
mcpu_scoreboard.sv
mcpu_decode_reg.sv
mcpu_decode_stage.sv
tb_mcpu_decode_stage.sv

// File: mcpu_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_decode_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [31:0]          inst,
  input  logic [31:0]          nextinst,
  input  logic                 inst_valid,
  output logic                 inst_ready,
  input  mcpu_pipe_pkg::wb_t   wb,
  output mcpu_pipe_pkg::d2pc_t issue
);

  import mcpu_pipe_pkg::*;

  d2pc_t       decoded;
  logic [4:0]  rs_num, rt_num;
  logic [31:0] rs_data, rt_data;
  logic [2:0]  preds;
  logic [31:0] reg_scoreboard;
  logic [2:0]  pred_scoreboard;
  logic        prev_long_imm;
  logic        dep_stall;
  logic        fire;

  assign inst_ready = ~(inst_valid & dep_stall);      // Hold fetch while a dependency is pending
  assign fire       = inst_valid & inst_ready;

  mcpu_decode mcpu_decode_inst (
    .inst            (inst),
    .nextinst        (nextinst),
    .prev_long_imm   (prev_long_imm),
    .preds           (preds),
    .reg_scoreboard  (reg_scoreboard),
    .pred_scoreboard (pred_scoreboard),
    .rs_data         (rs_data),
    .rt_data         (rt_data),
    .rs_num          (rs_num),
    .rt_num          (rt_num),
    .decoded         (decoded),
    .dep_stall       (dep_stall)
  );

  mcpu_regfile mcpu_regfile_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs_num  (rs_num),
    .rt_num  (rt_num),
    .rs_data (rs_data),
    .rt_data (rt_data),
    .preds   (preds),
    .wb      (wb)
  );

  mcpu_scoreboard mcpu_scoreboard_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue_fire      (fire),
    .issue_rd_num    (decoded.rd_num),
    .issue_rd_we     (decoded.rd_we),
    .issue_pred_we   (decoded.pred_we),
    .wb              (wb),
    .reg_scoreboard  (reg_scoreboard),
    .pred_scoreboard (pred_scoreboard)
  );

  mcpu_decode_reg mcpu_decode_reg_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .fire          (fire),
    .decoded       (decoded),
    .issue         (issue),
    .prev_long_imm (prev_long_imm)
  );

endmodule

`default_nettype wire

// File: mcpu_isa_pkg.sv
`default_nettype none

package mcpu_isa_pkg;

  // Register file and predicate geometry
  localparam int num_regs  = 32;
  localparam int num_preds = 3;                      // Index 3 is the hardwired true predicate

  // ALU compare writes a predicate, not a register
  localparam logic [3:0] cmp_opcode = 4'd7;

  // Link register used by branch-and-link
  localparam logic [4:0] branch_link_reg = 5'd31;

  // Execute unit that receives the issued bundle
  typedef enum logic [1:0] {
    oper_alu    = 2'd0,
    oper_lsu    = 2'd1,
    oper_branch = 2'd2,
    oper_other  = 2'd3
  } oper_type_e;

  // Sub-opcodes of the "other" group, taken from opcode bits [8:5]
  typedef enum logic [3:0] {
    other_break   = 4'd1,
    other_syscall = 4'd2,
    other_fence   = 4'd3,
    other_eret    = 4'd4,
    other_flush   = 4'd5,
    other_mfc     = 4'd6,
    other_mtc     = 4'd7,
    other_mult    = 4'd8,
    other_div     = 4'd9,
    other_mfhi    = 4'd10,
    other_mthi    = 4'd11
  } other_op_e;

endpackage

`default_nettype wire

// File: mcpu_pipe_pkg.sv
`default_nettype none

package mcpu_pipe_pkg;

  // Decoded bundle handed from decode to the execute units
  typedef struct packed {
    logic                     valid;
    logic [8:0]               execute_opcode;  // Units pick the bits they need
    logic [1:0]               shift_type;
    logic [5:0]               shift_amount;    // MSB flags a shift of 32 or more
    mcpu_isa_pkg::oper_type_e oper_type;
    logic [4:0]               rd_num;          // Low two bits name the predicate
    logic                     rd_we;
    logic                     pred_we;
    logic [31:0]              sop;             // Second operand or immediate
    logic [11:0]              lsu_offset;
    logic                     invalid;
    logic                     branchreg;
    logic                     long_imm;        // Next word is this one's immediate
  } d2pc_t;

  // Result returned from the execute side, one-cycle pulse
  typedef struct packed {
    logic        valid;
    logic [4:0]  rd_num;
    logic        rd_we;
    logic [31:0] rd_data;
    logic        pred_we;
    logic        pred_val;
  } wb_t;

endpackage

`default_nettype wire

// File: mcpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_regfile (
  input  logic               clk,
  input  logic               rst_n,
  input  logic [4:0]         rs_num,
  input  logic [4:0]         rt_num,
  output logic [31:0]        rs_data,
  output logic [31:0]        rt_data,
  output logic [2:0]         preds,
  input  mcpu_pipe_pkg::wb_t wb
);

  import mcpu_isa_pkg::*;

  logic [31:0]          regs [num_regs];
  logic [num_preds-1:0] pred_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (wb.valid && wb.rd_we) begin
      regs[wb.rd_num] <= wb.rd_data;
    end
  end

  // Predicate slot is the low two bits of the destination
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_q <= '0;
    end else if (wb.valid && wb.pred_we) begin
      pred_q[wb.rd_num[1:0]] <= wb.pred_val;
    end
  end

  // No bypass, a same-cycle writeback is seen next cycle
  assign rs_data = regs[rs_num];
  assign rt_data = regs[rt_num];
  assign preds   = pred_q;

  // Decoder never issues a write to the hardwired predicate
  a_no_pred3_write: assert property (
    @(posedge clk) disable iff (!rst_n)
    wb.valid && wb.pred_we |-> wb.rd_num[1:0] != 2'd3
  ) else $error("regfile: writeback targets predicate 3");

endmodule

`default_nettype wire

// File: mcpu_scoreboard.sv
`timescale 1ns/1ps
`default_nettype none

module mcpu_scoreboard (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               issue_fire,
  input  logic [4:0]         issue_rd_num,
  input  logic               issue_rd_we,
  input  logic               issue_pred_we,
  input  mcpu_pipe_pkg::wb_t wb,
  output logic [31:0]        reg_scoreboard,
  output logic [2:0]         pred_scoreboard
);

  import mcpu_isa_pkg::*;

  logic [num_regs-1:0]  reg_set, reg_clr;
  logic [num_preds-1:0] pred_set, pred_clr;

  assign reg_set  = (issue_fire && issue_rd_we)   ? num_regs'(1) << issue_rd_num : '0;
  assign pred_set = (issue_fire && issue_pred_we) ? num_preds'(1) << issue_rd_num[1:0] : '0;
  assign reg_clr  = (wb.valid && wb.rd_we)        ? num_regs'(1) << wb.rd_num : '0;
  assign pred_clr = (wb.valid && wb.pred_we)      ? num_preds'(1) << wb.rd_num[1:0] : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_scoreboard  <= '0;
      pred_scoreboard <= '0;
    end else begin
      reg_scoreboard  <= (reg_scoreboard & ~reg_clr) | reg_set;
      pred_scoreboard <= (pred_scoreboard & ~pred_clr) | pred_set;
    end
  end

  // Decoder stalls on a pending destination, so no double set
  a_set_clear_bit: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((reg_set & reg_scoreboard) == '0) && ((pred_set & pred_scoreboard) == '0)
  ) else $error("scoreboard: issue to a target already pending");

  // Every writeback answers an earlier issue
  a_clear_set_bit: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((reg_clr & ~reg_scoreboard) == '0) && ((pred_clr & ~pred_scoreboard) == '0)
  ) else $error("scoreboard: writeback to a target not pending");

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
verilator --binary --timing --assert --top-module tb_mcpu_decode_stage \
  -f mcpu_decode_stage.f || exit 1
out=$(./obj_dir/Vtb_mcpu_decode_stage)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

// File: tb_mcpu_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mcpu_decode_stage;

  import mcpu_isa_pkg::*;
  import mcpu_pipe_pkg::*;

  localparam int clk_period = 4;
  localparam int num_insts  = 400;

  logic        clk, rst_n;
  logic [31:0] inst, nextinst;
  logic        inst_valid, inst_ready;
  wb_t         wb;
  d2pc_t       issue;

  // Reference model state
  logic [31:0] m_regs [32];
  logic [2:0]  m_preds, m_psb;
  logic [31:0] m_sb;
  logic        m_pli;
  logic [31:0] lcg_state = 32'hcd62;
  logic [4:0]  wq_num [$];                            // Outstanding writes awaiting writeback
  logic        wq_pred [$];
  int          wq_wait [$];
  d2pc_t       exp_b;
  logic        exp_valid, wb_busy;
  string       exp_name, cur_name;
  int          n_acc, cyc, bundle_errs, hs_errs;
  string       class_name [8] = '{"alu_short", "alu_reg", "load_store", "branch",
                                  "other", "undefined", "reg_shift", "long_imm"};

  mcpu_decode_stage mcpu_decode_stage_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .nextinst   (nextinst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .wb         (wb),
    .issue      (issue)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state ^ {16'd0, lcg_state[31:16]};      // Fold high bits into the weak low ones
  endfunction

  function automatic logic [2:0] word_class(input logic [31:0] w);
    if (!w[28]) return 3'd0;
    if (w[27:26] == 2'b01) return 3'd1;
    if (w[27:25] == 3'b001) return 3'd2;
    if (w[27]) return 3'd3;
    if (w[24]) return 3'd4;
    if (w[23:22] != 2'b00) return 3'd5;
    if (w[21]) return 3'd6;
    if (w[20:14] != 7'd0) return 3'd5;
    return 3'd7;
  endfunction

  function automatic logic [31:0] make_word(input logic [2:0] cls);
    logic [31:0] w, r;
    w = next_rand();
    r = next_rand();
    if (r[17:16] != 2'd0) begin                       // Few registers give many hazards
      w[4:3]   = 2'd0;
      w[9:8]   = 2'd0;
      w[18:17] = 2'd0;
    end
    if (r[21:19] == 3'd0) w[13:10] = cmp_opcode;
    if (r[24:23] != 2'd0) w[31:29] = 3'b110;          // Always-true guard
    case (cls)
      3'd0: w[28] = 1'b0;
      3'd1: w[28:26] = 3'b101;
      3'd2: w[28:25] = 4'b1001;
      3'd3: w[28:27] = 2'b11;
      3'd4: w[28:24] = 5'b10001;
      3'd5: begin
        w[28:24] = 5'b10000;
        if (r[26]) begin
          w[23:22] = 2'b01;
        end else begin
          w[23:21] = 3'b000;
          w[16]    = 1'b1;
        end
      end
      3'd6: begin
        w[28:24] = 5'b10000;
        w[23:21] = 3'b001;
      end
      default: begin
        w[28:24] = 5'b10000;
        w[23:14] = 10'd0;
      end
    endcase
    return w;
  endfunction

  // Expected bundle and stall for a word from the model state before the edge
  task automatic predict(input logic [31:0] w, input logic [31:0] nw,
                         output d2pc_t b, output logic stall);
    logic [8:0]  opc;
    logic [3:0]  pext, psb;
    logic [31:0] rsv, rtv;
    logic        guard, cmp, use_rs, use_rt;
    opc    = {w[23:19], w[13:10]};
    rsv    = m_regs[w[4:0]];
    rtv    = m_regs[w[18:14]];
    pext   = {1'b1, m_preds};
    psb    = {1'b0, m_psb};
    guard  = (pext[w[31:30]] ^ w[29]) && !m_pli;
    cmp    = opc[3:0] == cmp_opcode;
    use_rs = 1'b0;
    use_rt = 1'b0;
    b = '0;
    b.valid          = 1'b1;
    b.execute_opcode = opc;
    b.rd_num         = w[9:5];
    b.oper_type      = oper_alu;
    b.lsu_offset     = opc[2] ? {w[24:19], w[13], w[9:5]} : w[24:13];
    if (guard) begin
      case (word_class(w))
        3'd0: begin
          b.rd_we        = !cmp;
          b.pred_we      = cmp && (w[6:5] != 2'd3);
          b.shift_type   = 2'b11;
          b.shift_amount = {1'b0, w[17:14], 1'b0};
          b.sop          = opc[3] ? {17'd0, w[4:0], w[27:18]} : {22'd0, w[27:18]};
          use_rs         = !opc[3];
        end
        3'd1: begin
          b.sop          = rtv;
          b.rd_we        = !cmp;
          b.pred_we      = cmp && (w[6:5] != 2'd3);
          b.shift_amount = {1'b0, w[25:21]};
          b.shift_type   = w[20:19];
          use_rt         = 1'b1;
          use_rs         = !opc[3];
        end
        3'd2: begin
          b.oper_type = oper_lsu;
          b.sop       = rtv;
          b.rd_we     = !opc[2];
          use_rs      = 1'b1;
          use_rt      = opc[2];
        end
        3'd3: begin
          b.oper_type = oper_branch;
          b.rd_num    = branch_link_reg;
          b.rd_we     = w[25];
          b.branchreg = w[26];
          use_rs      = w[26];
          b.sop = w[26] ? {4'd0, {8{w[24]}}, w[24:5]} : {4'd0, {3{w[24]}}, w[24:0]};
        end
        3'd4: begin
          b.oper_type = oper_other;
          b.sop       = rtv;
          case (w[23:20])
            4'd1, 4'd2, 4'd3, 4'd4: begin
            end
            4'd5, 4'd7, 4'd11: use_rs = 1'b1;
            4'd6, 4'd10: b.rd_we = 1'b1;
            4'd8, 4'd9: begin
              use_rs  = 1'b1;
              use_rt  = 1'b1;
              b.rd_we = 1'b1;
            end
            default: b.invalid = 1'b1;
          endcase
        end
        3'd5: b.invalid = 1'b1;
        3'd6: begin
          use_rs         = 1'b1;
          use_rt         = 1'b1;
          b.rd_we        = 1'b1;
          b.shift_type   = w[20:19];
          b.shift_amount = {rsv >= 32'd32, rsv[4:0]};  // MSB set for a shift of 32 or more
          b.sop          = rtv;
        end
        default: begin
          b.sop      = nw;
          b.long_imm = 1'b1;
          use_rs     = !opc[3];
          b.rd_we    = !cmp;
          b.pred_we  = cmp && (w[6:5] != 2'd3);
        end
      endcase
    end
    stall = (use_rt && m_sb[w[18:14]]) || (use_rs && m_sb[w[4:0]]) ||
            (psb[w[31:30]] && !m_pli) || (b.rd_we && m_sb[b.rd_num]) ||
            (b.pred_we && psb[b.rd_num[1:0]]);
  endtask

  // Check the outputs, update the model and drive the next inputs
  task automatic step_cycle();
    d2pc_t       b;
    wb_t         wv;
    logic        stall, acc;
    logic [31:0] r;
    int          pick;
    cyc = cyc + 1;
    assert (issue.valid === exp_valid) else begin
      hs_errs = hs_errs + 1;
      $display("Mismatch issue_valid: expected %0b actual %0b", exp_valid, issue.valid);
    end
    if (exp_valid) begin
      assert (issue === exp_b) else begin
        bundle_errs = bundle_errs + 1;
        $display("Mismatch %s: expected %h actual %h", exp_name, exp_b, issue);
      end
    end
    predict(inst, nextinst, b, stall);
    assert (inst_ready === !(inst_valid && stall)) else begin
      hs_errs = hs_errs + 1;
      $display("Mismatch inst_ready %s: expected %0b actual %0b",
               cur_name, !(inst_valid && stall), inst_ready);
    end
    acc       = inst_valid && !stall;
    exp_valid = acc;
    if (acc) begin
      exp_b    = b;
      exp_name = cur_name;
      n_acc    = n_acc + 1;
    end
    if (wb.valid && wb.rd_we) begin
      m_regs[wb.rd_num] = wb.rd_data;
      m_sb[wb.rd_num]   = 1'b0;
    end
    if (wb.valid && wb.pred_we) begin
      m_preds[wb.rd_num[1:0]] = wb.pred_val;
      m_psb[wb.rd_num[1:0]]   = 1'b0;
    end
    if (acc) begin
      if (b.rd_we) m_sb[b.rd_num] = 1'b1;
      if (b.pred_we) m_psb[b.rd_num[1:0]] = 1'b1;
      m_pli = b.long_imm;
    end
    // Writeback agent returns at most one result per cycle
    foreach (wq_wait[i]) wq_wait[i] = wq_wait[i] - 1;
    pick = -1;
    foreach (wq_wait[i]) if (pick < 0 && wq_wait[i] <= 0) pick = i;
    wb_busy = pick >= 0;
    wv = '0;
    if (wb_busy) begin
      r = next_rand();
      wv.valid    = 1'b1;
      wv.rd_num   = wq_num[pick];
      wv.rd_we    = !wq_pred[pick];
      wv.rd_data  = r;
      wv.pred_we  = wq_pred[pick];
      wv.pred_val = r[13];
      wq_num.delete(pick);
      wq_pred.delete(pick);
      wq_wait.delete(pick);
    end
    wb <= wv;
    if (issue.valid && (issue.rd_we || issue.pred_we)) begin
      r = next_rand();
      wq_num.push_back(issue.rd_num);
      wq_pred.push_back(issue.pred_we);
      wq_wait.push_back(int'(r[25:24]) + 1);
    end
    // Fetch side holds the word while stalled
    if (!(inst_valid && stall)) begin
      r = next_rand();
      if (n_acc < num_insts && cyc > 3 && r[31:30] != 2'b00) begin
        cur_name   = m_pli ? "imm_word" : class_name[r[22:20]];
        inst       <= m_pli ? nextinst : make_word(r[22:20]);
        nextinst   <= next_rand();
        inst_valid <= 1'b1;
      end else begin
        inst_valid <= 1'b0;
      end
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    inst        = '0;
    nextinst    = '0;
    inst_valid  = 1'b0;
    wb          = '0;
    m_regs      = '{default: '0};
    m_preds     = '0;
    m_psb       = '0;
    m_sb        = '0;
    m_pli       = 1'b0;
    exp_valid   = 1'b0;
    wb_busy     = 1'b0;
    cur_name    = "idle";
    n_acc       = 0;
    cyc         = 0;
    bundle_errs = 0;
    hs_errs     = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    while (n_acc < num_insts || exp_valid || wb_busy || wq_wait.size() != 0) begin
      @(posedge clk);
      step_cycle();
    end
    $display("Errors: %0d bundle mismatches, %0d handshake mismatches, %0d instructions",
             bundle_errs, hs_errs, n_acc);
    if (bundle_errs == 0 && hs_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(num_insts * 12 * clk_period);
    $display("Watchdog timeout: only %0d of %0d instructions were accepted", n_acc, num_insts);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
